//--- gfx_pkg.sv
package gfx_pkg;

  // pixel layout, red in the top field, then green, then blue
  localparam int PIXEL_BITS = 12;
  localparam int COLOR_BITS = PIXEL_BITS / 3;

  // horizontal raster in clock cycles
  localparam int H_VISIBLE     = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE  = 3;
  localparam int H_BACK_PORCH  = 3;
  localparam int H_WHOLE_LINE  = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

  // vertical raster in lines
  localparam int V_VISIBLE     = 12;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 2;
  localparam int V_BACK_PORCH  = 2;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

  // raster counter widths
  localparam int H_CNT_BITS = $clog2(H_WHOLE_LINE);
  localparam int V_CNT_BITS = $clog2(V_WHOLE_FRAME);

  // client coordinates
  localparam int FB_X_BITS = $clog2(H_VISIBLE);
  localparam int FB_Y_BITS = $clog2(V_VISIBLE);

  // one bank holds a whole visible frame
  localparam int FB_DEPTH     = H_VISIBLE * V_VISIBLE;
  localparam int FB_ADDR_BITS = $clog2(FB_DEPTH);

  // swap settling window
  localparam int SWITCH_HOLD_CYCLES = 8;
  localparam int HOLD_CNT_BITS      = $clog2(SWITCH_HOLD_CYCLES);

  typedef enum logic {
    SWAP_IDLE,
    SWAP_HOLD
  } swap_state_t;

endpackage

//--- fb_bank.sv
`timescale 1ns/1ps

module fb_bank (
  input  logic                             clk,

  input  logic                             wr_en,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr,
  input  logic [gfx_pkg::PIXEL_BITS-1:0]   wr_data,

  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  output logic [gfx_pkg::PIXEL_BITS-1:0]   rd_data
);

  logic [gfx_pkg::PIXEL_BITS-1:0] mem [gfx_pkg::FB_DEPTH];

  // client write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // display read port, one cycle of latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- fb_swap_ctrl.sv
`timescale 1ns/1ps

module fb_swap_ctrl (
  input  logic clk,
  input  logic rst_n,

  input  logic mem_switch,

  output logic hold,
  output logic front_sel
);

  gfx_pkg::swap_state_t                state;
  logic [gfx_pkg::HOLD_CNT_BITS-1:0]   hold_cnt;
  logic                                switch_q;
  logic                                switch_qq;
  logic                                switch_rise;

  // two sample stages, edge is seen one cycle after mem_switch is sampled high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      switch_q  <= 1'b0;
      switch_qq <= 1'b0;
    end else begin
      switch_q  <= mem_switch;
      switch_qq <= switch_q;
    end
  end

  assign switch_rise = switch_q & ~switch_qq;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= gfx_pkg::SWAP_IDLE;
      hold_cnt  <= '0;
      front_sel <= 1'b0;
    end else begin
      case (state)
        gfx_pkg::SWAP_IDLE: begin
          hold_cnt <= '0;
          if (switch_rise) begin
            state <= gfx_pkg::SWAP_HOLD;
          end
        end
        gfx_pkg::SWAP_HOLD: begin
          // last cycle of the window, hand the back bank to the display
          if (hold_cnt == gfx_pkg::HOLD_CNT_BITS'(gfx_pkg::SWITCH_HOLD_CYCLES - 1)) begin
            state     <= gfx_pkg::SWAP_IDLE;
            hold_cnt  <= '0;
            front_sel <= ~front_sel;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: begin
          state <= gfx_pkg::SWAP_IDLE;
        end
      endcase
    end
  end

  assign hold = (state == gfx_pkg::SWAP_HOLD);

endmodule

//--- fb_writer.sv
`timescale 1ns/1ps

module fb_writer (
  input  logic [gfx_pkg::FB_X_BITS-1:0]    gfx_x,
  input  logic [gfx_pkg::FB_Y_BITS-1:0]    gfx_y,
  input  logic [gfx_pkg::PIXEL_BITS-1:0]   gfx_color,
  input  logic                             gfx_valid,
  output logic                             gfx_ready,

  input  logic                             hold,
  input  logic                             front_sel,

  output logic                             wr_en0,
  output logic                             wr_en1,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr,
  output logic [gfx_pkg::PIXEL_BITS-1:0]   wr_data
);

  logic accept;
  logic in_range;
  logic do_write;

  // only stalled while the buffers settle
  assign gfx_ready = ~hold;
  assign accept    = gfx_valid & gfx_ready;

  // off-screen pixels are taken but never stored
  assign in_range = (32'(gfx_x) < gfx_pkg::H_VISIBLE) && (32'(gfx_y) < gfx_pkg::V_VISIBLE);
  assign do_write = accept & in_range;

  // row-major layout
  assign wr_addr = gfx_pkg::FB_ADDR_BITS'(32'(gfx_y) * gfx_pkg::H_VISIBLE + 32'(gfx_x));
  assign wr_data = gfx_color;

  // back bank is whichever one is not on screen
  assign wr_en0 = do_write & front_sel;
  assign wr_en1 = do_write & ~front_sel;

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             enable,

  output logic                             hsync,
  output logic                             vsync,
  output logic                             visible,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] pix_addr
);

  localparam int H_SYNC_START = gfx_pkg::H_VISIBLE + gfx_pkg::H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + gfx_pkg::H_SYNC_PULSE;
  localparam int V_SYNC_START = gfx_pkg::V_VISIBLE + gfx_pkg::V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + gfx_pkg::V_SYNC_PULSE;

  logic [gfx_pkg::H_CNT_BITS-1:0] h_cnt;
  logic [gfx_pkg::V_CNT_BITS-1:0] v_cnt;
  logic                           h_last;
  logic                           v_last;

  assign h_last = (h_cnt == gfx_pkg::H_CNT_BITS'(gfx_pkg::H_WHOLE_LINE - 1));
  assign v_last = (v_cnt == gfx_pkg::V_CNT_BITS'(gfx_pkg::V_WHOLE_FRAME - 1));

  // counters park at the origin while disabled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      if (v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // sync and blanking decode, forced idle when disabled
  always_comb begin
    hsync   = 1'b1;
    vsync   = 1'b1;
    visible = 1'b0;
    if (enable) begin
      if (32'(h_cnt) >= H_SYNC_START && 32'(h_cnt) < H_SYNC_END) begin
        hsync = 1'b0;
      end
      if (32'(v_cnt) >= V_SYNC_START && 32'(v_cnt) < V_SYNC_END) begin
        vsync = 1'b0;
      end
      visible = (32'(h_cnt) < gfx_pkg::H_VISIBLE) && (32'(v_cnt) < gfx_pkg::V_VISIBLE);
    end
  end

  // only meaningful inside the visible area
  assign pix_addr = gfx_pkg::FB_ADDR_BITS'(32'(v_cnt) * gfx_pkg::H_VISIBLE + 32'(h_cnt));

endmodule

//--- vga_fb_pixel_stream.sv
`timescale 1ns/1ps

module vga_fb_pixel_stream (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             enable,
  input  logic                             front_sel,

  output logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  input  logic [gfx_pkg::PIXEL_BITS-1:0]   rd_data0,
  input  logic [gfx_pkg::PIXEL_BITS-1:0]   rd_data1,

  output logic [gfx_pkg::COLOR_BITS-1:0]   vga_red,
  output logic [gfx_pkg::COLOR_BITS-1:0]   vga_grn,
  output logic [gfx_pkg::COLOR_BITS-1:0]   vga_blu,
  output logic                             vga_hsync,
  output logic                             vga_vsync
);

  logic                           hsync;
  logic                           vsync;
  logic                           visible;
  logic                           hsync_d;
  logic                           vsync_d;
  logic                           visible_d;
  logic                           sel_d;
  logic [gfx_pkg::PIXEL_BITS-1:0] pixel;

  vga_timing vga_timing_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (enable),
    .hsync   (hsync),
    .vsync   (vsync),
    .visible (visible),
    .pix_addr(rd_addr)
  );

  // stage 1, matches the bank read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
      visible_d <= 1'b0;
      sel_d     <= 1'b0;
    end else begin
      hsync_d   <= hsync;
      vsync_d   <= vsync;
      visible_d <= visible;
      sel_d     <= front_sel;
    end
  end

  // bank that was front when the read was issued
  assign pixel = sel_d ? rd_data1 : rd_data0;

  // stage 2, output register with blanking
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
      if (visible_d) begin
        vga_red <= pixel[gfx_pkg::PIXEL_BITS-1 -: gfx_pkg::COLOR_BITS];
        vga_grn <= pixel[2*gfx_pkg::COLOR_BITS-1 -: gfx_pkg::COLOR_BITS];
        vga_blu <= pixel[gfx_pkg::COLOR_BITS-1:0];
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
    end
  end

endmodule

//--- gfx_vga_dbuf.sv
`timescale 1ns/1ps

module gfx_vga_dbuf (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           mem_switch,

  // drawing client
  input  logic [gfx_pkg::FB_X_BITS-1:0]  gfx_x,
  input  logic [gfx_pkg::FB_Y_BITS-1:0]  gfx_y,
  input  logic [gfx_pkg::PIXEL_BITS-1:0] gfx_color,
  input  logic                           gfx_valid,
  output logic                           gfx_ready,
  output logic                           gfx_vsync,

  // display
  input  logic                           vga_enable,
  output logic [gfx_pkg::COLOR_BITS-1:0] vga_red,
  output logic [gfx_pkg::COLOR_BITS-1:0] vga_grn,
  output logic [gfx_pkg::COLOR_BITS-1:0] vga_blu,
  output logic                           vga_hsync,
  output logic                           vga_vsync
);

  logic                             hold;
  logic                             front_sel;
  logic                             wr_en0;
  logic                             wr_en1;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr;
  logic [gfx_pkg::PIXEL_BITS-1:0]   wr_data;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr;
  logic [gfx_pkg::PIXEL_BITS-1:0]   rd_data0;
  logic [gfx_pkg::PIXEL_BITS-1:0]   rd_data1;

  fb_swap_ctrl fb_swap_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_switch(mem_switch),
    .hold      (hold),
    .front_sel (front_sel)
  );

  fb_writer fb_writer_inst (
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_valid(gfx_valid),
    .gfx_ready(gfx_ready),
    .hold     (hold),
    .front_sel(front_sel),
    .wr_en0   (wr_en0),
    .wr_en1   (wr_en1),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  // both banks share the write and read buses, strobes pick the target
  fb_bank bank0 (
    .clk    (clk),
    .wr_en  (wr_en0),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data0)
  );

  fb_bank bank1 (
    .clk    (clk),
    .wr_en  (wr_en1),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data1)
  );

  vga_fb_pixel_stream vga_fb_pixel_stream_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (vga_enable),
    .front_sel(front_sel),
    .rd_addr  (rd_addr),
    .rd_data0 (rd_data0),
    .rd_data1 (rd_data1),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

  // lets the client pace its drawing to the display
  assign gfx_vsync = vga_vsync;

endmodule

//--- gfx_vga_dbuf_tb.sv
`timescale 1ns/1ps

module gfx_vga_dbuf_tb;

  typedef enum int {
    OP_RESET,
    OP_FILL,
    OP_POKE,
    OP_SWAP,
    OP_SWAP_BUSY,
    OP_DISABLE,
    OP_FRAME
  } op_t;

  logic                           clk;
  logic                           rst_n;
  logic                           mem_switch;
  logic [gfx_pkg::FB_X_BITS-1:0]  gfx_x;
  logic [gfx_pkg::FB_Y_BITS-1:0]  gfx_y;
  logic [gfx_pkg::PIXEL_BITS-1:0] gfx_color;
  logic                           gfx_valid;
  logic                           gfx_ready;
  logic                           gfx_vsync;
  logic                           vga_enable;
  logic [gfx_pkg::COLOR_BITS-1:0] vga_red;
  logic [gfx_pkg::COLOR_BITS-1:0] vga_grn;
  logic [gfx_pkg::COLOR_BITS-1:0] vga_blu;
  logic                           vga_hsync;
  logic                           vga_vsync;

  // stimulus table, one entry per row in each queue
  string row_name[$];
  op_t   row_op[$];
  int    row_x[$];
  int    row_y[$];
  int    row_color[$];
  int    row_exp[$];

  // model of both banks and of which one is on screen
  logic [gfx_pkg::PIXEL_BITS-1:0] model [2][gfx_pkg::FB_DEPTH];
  logic                           front_idx;
  logic [31:0]                    lcg_state;
  int                             checks;
  int                             errors;
  int                             cycle_cnt;
  int                             cycle_limit;

  gfx_vga_dbuf UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_switch(mem_switch),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_enable(vga_enable),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("Error %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input op_t op, input int x, input int y,
                         input int color, input int exp);
    row_name.push_back(name);
    row_op.push_back(op);
    row_x.push_back(x);
    row_y.push_back(y);
    row_color.push_back(color);
    row_exp.push_back(exp);
  endtask

  function automatic int row_budget(input op_t op);
    case (op)
      OP_FILL:      return gfx_pkg::FB_DEPTH + 8;
      OP_SWAP:      return 30;
      OP_SWAP_BUSY: return 30;
      OP_DISABLE:   return 40;
      OP_FRAME:     return 2 * gfx_pkg::H_WHOLE_LINE * gfx_pkg::V_WHOLE_FRAME + 4;
      default:      return 4;
    endcase
  endfunction

  // one client write, held until accepted, stored in the back bank model
  task automatic write_pixel(input int x, input int y, input logic [11:0] c);
    logic [gfx_pkg::FB_ADDR_BITS-1:0] addr;
    gfx_x     = gfx_pkg::FB_X_BITS'(x);
    gfx_y     = gfx_pkg::FB_Y_BITS'(y);
    gfx_color = c;
    gfx_valid = 1'b1;
    @(negedge clk);
    while (!gfx_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    gfx_valid = 1'b0;
    if (y < gfx_pkg::V_VISIBLE) begin
      addr = gfx_pkg::FB_ADDR_BITS'(y * gfx_pkg::H_VISIBLE + x);
      model[front_idx ^ 1'b1][addr] = c;
    end
  endtask

  task automatic fill_back();
    int a;
    for (a = 0; a < gfx_pkg::FB_DEPTH; a++) begin
      lcg_state = lcg_next(lcg_state);
      write_pixel(a % gfx_pkg::H_VISIBLE, a / gfx_pkg::H_VISIBLE, lcg_state[27:16]);
    end
  endtask

  task automatic check_reset(input string name, input int exp);
    @(negedge clk);
    compare_value({name, " ready"}, exp, 32'(gfx_ready));
    compare_value({name, " syncs"}, 32'h7, 32'({vga_hsync, vga_vsync, gfx_vsync}));
    compare_value({name, " color"}, 0, 32'({vga_red, vga_grn, vga_blu}));
    @(posedge clk);
    #2;
  endtask

  // sample k is taken after k-1 edges past the edge that sees mem_switch high
  task automatic run_swap(input string name, input logic busy, input int x, input int y,
                          input logic [11:0] c, input int exp_low);
    int   k;
    int   first_low;
    int   low_cnt;
    int   accept_k;
    logic ready_q;
    first_low  = -1;
    low_cnt    = 0;
    accept_k   = -1;
    ready_q    = 1'b0;
    mem_switch = 1'b1;
    for (k = 1; k <= 24; k++) begin
      @(posedge clk);
      if (gfx_valid && ready_q) begin
        accept_k = k;
      end
      #2;
      if (accept_k == k) begin
        gfx_valid = 1'b0;
      end
      if (busy && k == 2) begin
        gfx_x     = gfx_pkg::FB_X_BITS'(x);
        gfx_y     = gfx_pkg::FB_Y_BITS'(y);
        gfx_color = c;
        gfx_valid = 1'b1;
      end
      // second rising edge lands inside the window
      if (k == 3 || k == 7) begin
        mem_switch = 1'b0;
      end
      if (busy && k == 5) begin
        mem_switch = 1'b1;
      end
      @(negedge clk);
      ready_q = gfx_ready;
      if (!gfx_ready) begin
        if (first_low < 0) begin
          first_low = k;
        end
        low_cnt = low_cnt + 1;
      end
    end
    compare_value({name, " ready low start"}, 2, first_low);
    compare_value({name, " ready low cycles"}, exp_low, low_cnt);
    front_idx = front_idx ^ 1'b1;
    if (busy) begin
      compare_value({name, " held write edge"}, 2 + exp_low + 1, accept_k);
      if (accept_k > 0 && y < gfx_pkg::V_VISIBLE) begin
        model[front_idx ^ 1'b1][gfx_pkg::FB_ADDR_BITS'(y * gfx_pkg::H_VISIBLE + x)] = c;
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic check_disable(input string name);
    int k;
    vga_enable = 1'b0;
    for (k = 1; k <= 30; k++) begin
      @(negedge clk);
      if (k >= 3) begin
        compare_value({name, " syncs"}, 32'h3, 32'({vga_hsync, vga_vsync}));
        compare_value({name, " color"}, 0, 32'({vga_red, vga_grn, vga_blu}));
      end
    end
    @(posedge clk);
    #2;
    vga_enable = 1'b1;
    // read and output register
    repeat (3) @(negedge clk);
    compare_value({name, " first pixel"}, 32'(model[front_idx][0]),
                  32'({vga_red, vga_grn, vga_blu}));
    @(posedge clk);
    #2;
  endtask

  task automatic check_frame(input string name, input int exp_vs_low);
    int   i;
    int   p;
    int   h;
    int   v;
    int   hs_low;
    int   vs_low;
    int   line_len;
    int   frame_len;
    logic prev_vs;
    logic exp_hs;
    logic exp_vs;
    logic [gfx_pkg::PIXEL_BITS-1:0] exp_pix;
    line_len  = gfx_pkg::H_WHOLE_LINE;
    frame_len = line_len * gfx_pkg::V_WHOLE_FRAME;
    hs_low    = 0;
    vs_low    = 0;
    prev_vs   = 1'b1;
    @(negedge clk);
    while (prev_vs !== 1'b0 || vga_vsync !== 1'b1) begin
      prev_vs = vga_vsync;
      @(negedge clk);
    end
    // vsync rise shows h=0 of the first back porch line
    for (i = 0; i < frame_len; i++) begin
      p = ((gfx_pkg::V_WHOLE_FRAME - gfx_pkg::V_BACK_PORCH) * line_len + i) % frame_len;
      h = p % line_len;
      v = p / line_len;
      exp_hs = !(h >= gfx_pkg::H_VISIBLE + gfx_pkg::H_FRONT_PORCH &&
                 h < line_len - gfx_pkg::H_BACK_PORCH);
      exp_vs = !(v >= gfx_pkg::V_VISIBLE + gfx_pkg::V_FRONT_PORCH &&
                 v < gfx_pkg::V_WHOLE_FRAME - gfx_pkg::V_BACK_PORCH);
      exp_pix = '0;
      if (h < gfx_pkg::H_VISIBLE && v < gfx_pkg::V_VISIBLE) begin
        exp_pix = model[front_idx][gfx_pkg::FB_ADDR_BITS'(v * gfx_pkg::H_VISIBLE + h)];
      end
      if (!vga_hsync) begin
        hs_low = hs_low + 1;
      end
      if (!vga_vsync) begin
        vs_low = vs_low + 1;
      end
      // client vsync follows the display vsync
      compare_value($sformatf("%s sync h%0d v%0d", name, h, v),
                    32'({exp_hs, exp_vs, exp_vs}),
                    32'({vga_hsync, vga_vsync, gfx_vsync}));
      compare_value($sformatf("%s pixel h%0d v%0d", name, h, v), 32'(exp_pix),
                    32'({vga_red, vga_grn, vga_blu}));
      if (i < frame_len - 1) begin
        @(negedge clk);
      end
    end
    compare_value({name, " vsync low"}, exp_vs_low, vs_low);
    compare_value({name, " hsync low"}, gfx_pkg::H_SYNC_PULSE * gfx_pkg::V_WHOLE_FRAME, hs_low);
    @(posedge clk);
    #2;
  endtask

  task automatic run_row(input int r);
    case (row_op[r])
      OP_RESET:     check_reset(row_name[r], row_exp[r]);
      OP_FILL:      fill_back();
      OP_POKE:      write_pixel(row_x[r], row_y[r], 12'(row_color[r]));
      OP_SWAP:      run_swap(row_name[r], 1'b0, 0, 0, 12'h000, row_exp[r]);
      OP_SWAP_BUSY: run_swap(row_name[r], 1'b1, row_x[r], row_y[r], 12'(row_color[r]),
                             row_exp[r]);
      OP_DISABLE:   check_disable(row_name[r]);
      default:      check_frame(row_name[r], row_exp[r]);
    endcase
  endtask

  initial begin
    int r;
    clk         = 1'b0;
    rst_n       = 1'b0;
    mem_switch  = 1'b0;
    gfx_x       = '0;
    gfx_y       = '0;
    gfx_color   = '0;
    gfx_valid   = 1'b0;
    vga_enable  = 1'b1;
    front_idx   = 1'b0;
    lcg_state   = 32'h2e19;
    checks      = 0;
    errors      = 0;
    cycle_cnt   = 0;
    add_row("reset_state",     OP_RESET,     0,  0, 0,      1);
    add_row("fill_a",          OP_FILL,      0,  0, 0,      0);
    add_row("swap_a",          OP_SWAP,      0,  0, 0,      8);
    add_row("frame_a",         OP_FRAME,     0,  0, 0,      48);
    add_row("fill_b",          OP_FILL,      0,  0, 0,      0);
    add_row("poke_corner",     OP_POKE,      0,  0, 'hf00,  0);
    add_row("poke_mid",        OP_POKE,      7,  5, 'h0f0,  0);
    add_row("poke_last",       OP_POKE,      15, 11, 'h00f, 0);
    add_row("poke_offscreen",  OP_POKE,      3,  13, 'hfff, 0);
    add_row("frame_unchanged", OP_FRAME,     0,  0, 0,      48);
    add_row("swap_busy",       OP_SWAP_BUSY, 9,  2, 'h5a5,  8);
    add_row("frame_b",         OP_FRAME,     0,  0, 0,      48);
    add_row("enable_off",      OP_DISABLE,   0,  0, 0,      0);
    add_row("swap_c",          OP_SWAP,      0,  0, 0,      8);
    add_row("frame_c",         OP_FRAME,     0,  0, 0,      48);
    // reset, every row and some slack
    cycle_limit = 16 + 200;
    for (r = 0; r < row_op.size(); r++) begin
      cycle_limit = cycle_limit + row_budget(row_op[r]);
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (r = 0; r < row_op.size(); r++) begin
      run_row(r);
    end
    $display("Checks run: %0d, errors found: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- gfx_vga_dbuf.f
gfx_pkg.sv
fb_bank.sv
fb_swap_ctrl.sv
fb_writer.sv
vga_timing.sv
vga_fb_pixel_stream.sv
gfx_vga_dbuf.sv
gfx_vga_dbuf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the frame buffer testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

TOP=gfx_vga_dbuf_tb
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --top-module "$TOP" -Mdir "$BUILD_DIR" -f gfx_vga_dbuf.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$("./$BUILD_DIR/V$TOP" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -Fqx "All tests passed!"; then
  exit 0
fi
exit 1
